//--- common/pixel_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// One pixel per clock between display pipeline stages, no back-pressure
interface pixel_stream_if;
    import tracker_pkg::*;

    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic                hsync;
    logic                vsync;
    logic                active; // Inside the visible window
    logic [CHAN_W-1:0]   red;
    logic [CHAN_W-1:0]   green;
    logic [CHAN_W-1:0]   blue;
    logic                mask;   // Threshold result for this pixel

    modport src (
        output hcount, vcount,
        output hsync, vsync, active,
        output red, green, blue,
        output mask
    );

    modport dst (
        input hcount, vcount,
        input hsync, vsync, active,
        input red, green, blue,
        input mask
    );

endinterface

`default_nettype wire

//--- common/tracker_pkg.sv
`default_nettype none

package tracker_pkg;

    // Scaled-down raster, in pixels and lines
    localparam int H_ACTIVE = 64;
    localparam int H_TOTAL  = 80;
    localparam int V_ACTIVE = 48;
    localparam int V_TOTAL  = 52;

    // Sync is high for START <= count < END
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 72;
    localparam int V_SYNC_START = 49;
    localparam int V_SYNC_END   = 50;

    localparam int HCOUNT_W = $clog2(H_TOTAL);
    localparam int VCOUNT_W = $clog2(V_TOTAL);

    localparam int CHAN_W     = 8;  // One expanded colour channel
    localparam int PIXEL565_W = 16; // Frame-buffer word

    // Overlay geometry
    localparam int CROSS_ARM     = 8; // Half-length of each crosshair arm
    localparam int CROSS_THICK   = 1;
    localparam int BORDER        = 4;
    localparam int NUM_CENTROIDS = 2;

    // Threshold channel select, code 3 falls back to red
    localparam logic [1:0] SEL_RED   = 2'd0;
    localparam logic [1:0] SEL_GREEN = 2'd1;
    localparam logic [1:0] SEL_BLUE  = 2'd2;

    // Overlay colours as {red, green, blue}
    localparam logic [23:0] COLOR_CROSS = 24'hFFFF00; // Yellow
    localparam logic [23:0] COLOR_GOOD  = 24'h00FF00;
    localparam logic [23:0] COLOR_BAD   = 24'hFF0000;

endpackage

`default_nettype wire

//--- list.f
common/tracker_pkg.sv
common/pixel_stream_if.sv
rtl/video_timing.sv
rtl/mask_stage.sv
overlay/overlay_stage.sv
rtl/juggle_display_top.sv
verification/tb_juggle_display.sv

//--- overlay/overlay_stage.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_stage (
    input  wire                 clk_pixel,
    input  wire                 recent_reset,
    pixel_stream_if.dst         pix_i,
    input  wire                 mask_view_i,
    input  wire [tracker_pkg::NUM_CENTROIDS-1:0][tracker_pkg::HCOUNT_W-1:0] ball_x_i,
    input  wire [tracker_pkg::NUM_CENTROIDS-1:0][tracker_pkg::VCOUNT_W-1:0] ball_y_i,
    input  wire [1:0]           num_balls_i,
    input  wire                 pattern_correct_i,
    output logic [23:0]         rgb_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                de_o
);
    import tracker_pkg::*;

    logic [HCOUNT_W-1:0] dx [NUM_CENTROIDS];
    logic [VCOUNT_W-1:0] dy [NUM_CENTROIDS];
    logic                on_cross;
    logic                on_border;
    logic [23:0]         camera_rgb;
    logic [23:0]         rgb_next;

    // Distance from each centroid, then the plus-shaped hit test
    always_comb begin
        on_cross = 1'b0;
        for (int k = 0; k < NUM_CENTROIDS; k++) begin
            dx[k] = (pix_i.hcount > ball_x_i[k]) ? pix_i.hcount - ball_x_i[k]
                                                 : ball_x_i[k] - pix_i.hcount;
            dy[k] = (pix_i.vcount > ball_y_i[k]) ? pix_i.vcount - ball_y_i[k]
                                                 : ball_y_i[k] - pix_i.vcount;
            if (k < int'(num_balls_i)) begin // Only balls in play get a cross
                if ((dx[k] <= HCOUNT_W'(CROSS_THICK) && dy[k] <= VCOUNT_W'(CROSS_ARM))
                    || (dx[k] <= HCOUNT_W'(CROSS_ARM) && dy[k] <= VCOUNT_W'(CROSS_THICK)))
                begin
                    on_cross = 1'b1;
                end
            end
        end
    end

    // Judgment frame around the active window
    assign on_border = (pix_i.hcount <  HCOUNT_W'(BORDER))
                    || (pix_i.hcount >= HCOUNT_W'(H_ACTIVE - BORDER))
                    || (pix_i.vcount <  VCOUNT_W'(BORDER))
                    || (pix_i.vcount >= VCOUNT_W'(V_ACTIVE - BORDER));

    assign camera_rgb = {pix_i.red, pix_i.green, pix_i.blue};

    // Final video mux, highest priority first
    always_comb begin
        if (!pix_i.active) begin
            rgb_next = '0;
        end else if (on_cross) begin
            rgb_next = COLOR_CROSS;
        end else if (on_border) begin
            rgb_next = pattern_correct_i ? COLOR_GOOD : COLOR_BAD;
        end else if (mask_view_i) begin
            rgb_next = {24{pix_i.mask}}; // White where the mask is set
        end else begin
            rgb_next = camera_rgb;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            rgb_o   <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
        end else begin
            rgb_o   <= rgb_next;
            hsync_o <= pix_i.hsync;
            vsync_o <= pix_i.vsync;
            de_o    <= pix_i.active;
        end
    end

    // Display never sees colour during blanking
    black_in_blanking: assert property (
        @(posedge clk_pixel) disable iff (recent_reset)
        !de_o |-> (rgb_o == '0)
    );

    // Sync pulses sit outside the drawn area
    sync_outside_active: assert property (
        @(posedge clk_pixel) disable iff (recent_reset)
        (hsync_o || vsync_o) |-> !de_o
    );

endmodule

`default_nettype wire

//--- rtl/juggle_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module juggle_display_top (
    input  wire                                clk_pixel,
    input  wire                                recent_reset,
    // Frame-buffer pixel for the position on hcount_o, vcount_o
    input  wire [tracker_pkg::PIXEL565_W-1:0]  pixel_i,
    // Threshold controls
    input  wire [1:0]                          chan_sel_i,
    input  wire [tracker_pkg::CHAN_W-1:0]      lower_i,
    input  wire [tracker_pkg::CHAN_W-1:0]      upper_i,
    input  wire                                mask_view_i,
    // Tracked balls, entry 0 in the low bits
    input  wire [tracker_pkg::NUM_CENTROIDS*tracker_pkg::HCOUNT_W-1:0] ball_x_i,
    input  wire [tracker_pkg::NUM_CENTROIDS*tracker_pkg::VCOUNT_W-1:0] ball_y_i,
    input  wire [1:0]                          num_balls_i,
    input  wire                                pattern_correct_i,
    // Pixel request
    output logic [tracker_pkg::HCOUNT_W-1:0]   hcount_o,
    output logic [tracker_pkg::VCOUNT_W-1:0]   vcount_o,
    output logic                               new_frame_o,
    // Video out, two cycles behind the request
    output logic [23:0]                        rgb_o,
    output logic                               hsync_o,
    output logic                               vsync_o,
    output logic                               de_o
);

    pixel_stream_if timing_pix ();
    pixel_stream_if mask_pix ();

    assign hcount_o = timing_pix.hcount;
    assign vcount_o = timing_pix.vcount;

    video_timing video_timing_inst (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .new_frame_o  (new_frame_o),
        .pix_o        (timing_pix.src)
    );

    mask_stage mask_stage_inst (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .pixel_i      (pixel_i),
        .chan_sel_i   (chan_sel_i),
        .lower_i      (lower_i),
        .upper_i      (upper_i),
        .pix_i        (timing_pix.dst),
        .pix_o        (mask_pix.src)
    );

    overlay_stage overlay_stage_inst (
        .clk_pixel         (clk_pixel),
        .recent_reset      (recent_reset),
        .pix_i             (mask_pix.dst),
        .mask_view_i       (mask_view_i),
        .ball_x_i          (ball_x_i),
        .ball_y_i          (ball_y_i),
        .num_balls_i       (num_balls_i),
        .pattern_correct_i (pattern_correct_i),
        .rgb_o             (rgb_o),
        .hsync_o           (hsync_o),
        .vsync_o           (vsync_o),
        .de_o              (de_o)
    );

endmodule

`default_nettype wire

//--- rtl/mask_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mask_stage (
    input  wire                              clk_pixel,
    input  wire                              recent_reset,
    input  wire [tracker_pkg::PIXEL565_W-1:0] pixel_i,
    input  wire [1:0]                        chan_sel_i,
    input  wire [tracker_pkg::CHAN_W-1:0]    lower_i,
    input  wire [tracker_pkg::CHAN_W-1:0]    upper_i,
    pixel_stream_if.dst                      pix_i,
    pixel_stream_if.src                      pix_o
);
    import tracker_pkg::*;

    logic [CHAN_W-1:0] red;
    logic [CHAN_W-1:0] green;
    logic [CHAN_W-1:0] blue;
    logic [CHAN_W-1:0] chan;
    logic              in_band;

    // 5:6:5 unpack, low bits padded with zeros
    assign red   = {pixel_i[15:11], 3'b000};
    assign green = {pixel_i[10:5],  2'b00};
    assign blue  = {pixel_i[4:0],   3'b000};

    always_comb begin
        case (chan_sel_i)
            SEL_GREEN: chan = green;
            SEL_BLUE:  chan = blue;
            default:   chan = red; // SEL_RED and the unused code
        endcase
    end

    // Lower bound exclusive, upper bound inclusive
    assign in_band = (chan > lower_i) && (chan <= upper_i);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            pix_o.hsync  <= 1'b0;
            pix_o.vsync  <= 1'b0;
            pix_o.active <= 1'b0;
        end else begin
            pix_o.hsync  <= pix_i.hsync;
            pix_o.vsync  <= pix_i.vsync;
            pix_o.active <= pix_i.active;
        end
    end

    // Payload follows the position by one cycle
    always_ff @(posedge clk_pixel) begin
        pix_o.hcount <= pix_i.hcount;
        pix_o.vcount <= pix_i.vcount;
        if (pix_i.active) begin
            pix_o.red   <= red;
            pix_o.green <= green;
            pix_o.blue  <= blue;
            pix_o.mask  <= in_band;
        end else begin
            pix_o.red   <= '0; // Blanking carries no colour
            pix_o.green <= '0;
            pix_o.blue  <= '0;
            pix_o.mask  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  wire         clk_pixel,
    input  wire         recent_reset,
    output logic        new_frame_o,
    pixel_stream_if.src pix_o
);
    import tracker_pkg::*;

    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic                line_end;
    logic                frame_end;

    assign line_end  = (hcount == HCOUNT_W'(H_TOTAL - 1));
    assign frame_end = line_end && (vcount == VCOUNT_W'(V_TOTAL - 1));

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount      <= '0;
            vcount      <= '0;
            new_frame_o <= 1'b0;
        end else begin
            new_frame_o <= frame_end; // High while the counts sit at 0,0
            if (line_end) begin
                hcount <= '0;
                vcount <= frame_end ? '0 : vcount + 1'b1;
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    assign pix_o.hcount = hcount;
    assign pix_o.vcount = vcount;

    // Sync and draw window decoded straight from the counts
    assign pix_o.hsync  = (hcount >= HCOUNT_W'(H_SYNC_START))
                       && (hcount <  HCOUNT_W'(H_SYNC_END));
    assign pix_o.vsync  = (vcount >= VCOUNT_W'(V_SYNC_START))
                       && (vcount <  VCOUNT_W'(V_SYNC_END));
    assign pix_o.active = (hcount < HCOUNT_W'(H_ACTIVE))
                       && (vcount < VCOUNT_W'(V_ACTIVE));

    // Colour and mask are added by the next stage
    assign pix_o.red   = '0;
    assign pix_o.green = '0;
    assign pix_o.blue  = '0;
    assign pix_o.mask  = 1'b0;

    // Counter never leaves the frame
    hcount_in_range: assert property (
        @(posedge clk_pixel) disable iff (recent_reset)
        (hcount < HCOUNT_W'(H_TOTAL)) && (vcount < VCOUNT_W'(V_TOTAL))
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the display path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_juggle_display \
    -f list.f

# Pass only when the testbench reports it
./obj_dir/Vtb_juggle_display | tee /dev/stderr | grep "Testbench passed" > /dev/null
echo "run.sh: simulation finished without errors"

//--- verification/tb_juggle_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_juggle_display;
    import tracker_pkg::*;

    localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
    localparam int NUM_TEST_FRAMES = 10;
    // One spare frame on top of all test frames
    localparam int TIMEOUT_CYCLES  = (NUM_TEST_FRAMES + 1) * FRAME_CYCLES + 100;

    // Expected video for one output cycle
    typedef struct packed {
        logic [23:0] rgb;
        logic        hsync;
        logic        vsync;
        logic        de;
    } video_t;

    // Expected state one cycle after the request
    typedef struct packed {
        logic [HCOUNT_W-1:0] h;
        logic [VCOUNT_W-1:0] v;
        logic                hsync;
        logic                vsync;
        logic                active;
        logic [23:0]         rgb;
        logic                mask;
    } masked_t;

    logic                              clk_pixel = 1'b0;
    logic                              recent_reset;
    logic [PIXEL565_W-1:0]             pixel_i;
    logic [1:0]                        chan_sel_i;
    logic [CHAN_W-1:0]                 lower_i;
    logic [CHAN_W-1:0]                 upper_i;
    logic                              mask_view_i;
    logic [NUM_CENTROIDS*HCOUNT_W-1:0] ball_x_i;
    logic [NUM_CENTROIDS*VCOUNT_W-1:0] ball_y_i;
    logic [1:0]                        num_balls_i;
    logic                              pattern_correct_i;
    logic [HCOUNT_W-1:0]               hcount_o;
    logic [VCOUNT_W-1:0]               vcount_o;
    logic                              new_frame_o;
    logic [23:0]                       rgb_o;
    logic                              hsync_o;
    logic                              vsync_o;
    logic                              de_o;

    logic [PIXEL565_W-1:0] frame_mem [FRAME_CYCLES]; // Random frame buffer
    masked_t stage1;
    video_t  stage2;
    int      exp_h;
    int      exp_v;
    logic    exp_new_frame;
    string   test_name;
    int      cycle_count = 0;

    // Per-frame event counts
    int de_count;
    int hsync_count;
    int vsync_count;
    int frame_count;
    int cross_count;
    int good_count;
    int bad_count;
    int white_count;
    int at_lower_count;
    int at_upper_count;

    juggle_display_top juggle_display_top_inst (
        .clk_pixel         (clk_pixel),
        .recent_reset      (recent_reset),
        .pixel_i           (pixel_i),
        .chan_sel_i        (chan_sel_i),
        .lower_i           (lower_i),
        .upper_i           (upper_i),
        .mask_view_i       (mask_view_i),
        .ball_x_i          (ball_x_i),
        .ball_y_i          (ball_y_i),
        .num_balls_i       (num_balls_i),
        .pattern_correct_i (pattern_correct_i),
        .hcount_o          (hcount_o),
        .vcount_o          (vcount_o),
        .new_frame_o       (new_frame_o),
        .rgb_o             (rgb_o),
        .hsync_o           (hsync_o),
        .vsync_o           (vsync_o),
        .de_o              (de_o)
    );

    initial begin
        forever #50 clk_pixel = ~clk_pixel;
    end

    always @(posedge clk_pixel) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    // 5:6:5 word to 8-bit channels with zero padding
    function automatic logic [23:0] unpack565(input logic [PIXEL565_W-1:0] p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    function automatic logic [CHAN_W-1:0] select_channel(input logic [23:0] rgb,
                                                         input logic [1:0]  sel);
        case (sel)
            2'd1:    return rgb[15:8];
            2'd2:    return rgb[7:0];
            default: return rgb[23:16]; // Red, also for code 3
        endcase
    endfunction

    function automatic int abs_diff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic logic hits_crosshair(input int h, input int v);
        int   dx;
        int   dy;
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < int'(num_balls_i) && k < NUM_CENTROIDS; k++) begin
            dx = abs_diff(h, int'(ball_x_i[k*HCOUNT_W +: HCOUNT_W]));
            dy = abs_diff(v, int'(ball_y_i[k*VCOUNT_W +: VCOUNT_W]));
            if ((dx <= CROSS_THICK && dy <= CROSS_ARM) || (dx <= CROSS_ARM && dy <= CROSS_THICK))
                hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic logic in_border(input int h, input int v);
        return (h < BORDER) || (h >= H_ACTIVE - BORDER)
            || (v < BORDER) || (v >= V_ACTIVE - BORDER);
    endfunction

    // Output priority: blanking, crosshair, border, mask view, camera
    function automatic video_t expected_video(input masked_t s);
        video_t o;
        o.hsync = s.hsync;
        o.vsync = s.vsync;
        o.de    = s.active;
        if (!s.active)
            o.rgb = 24'h000000;
        else if (hits_crosshair(int'(s.h), int'(s.v)))
            o.rgb = COLOR_CROSS;
        else if (in_border(int'(s.h), int'(s.v)))
            o.rgb = pattern_correct_i ? COLOR_GOOD : COLOR_BAD;
        else if (mask_view_i)
            o.rgb = s.mask ? 24'hFFFFFF : 24'h000000;
        else
            o.rgb = s.rgb;
        return o;
    endfunction

    // Called at a falling edge with the inputs for the next rising edge in place
    task automatic advance_model();
        masked_t           next_s1;
        logic [23:0]       cam;
        logic [CHAN_W-1:0] chan;
        logic              shown;
        cam              = unpack565(pixel_i);
        chan             = select_channel(cam, chan_sel_i);
        next_s1.h        = HCOUNT_W'(exp_h);
        next_s1.v        = VCOUNT_W'(exp_v);
        next_s1.hsync    = (exp_h >= H_SYNC_START) && (exp_h < H_SYNC_END);
        next_s1.vsync    = (exp_v >= V_SYNC_START) && (exp_v < V_SYNC_END);
        next_s1.active   = (exp_h < H_ACTIVE) && (exp_v < V_ACTIVE);
        next_s1.rgb      = next_s1.active ? cam : 24'h000000;
        next_s1.mask     = next_s1.active && (chan > lower_i) && (chan <= upper_i);
        // Edge cases count only where the mask view shows the pixel
        shown            = next_s1.active && !in_border(exp_h, exp_v);
        if (shown && chan == lower_i) at_lower_count++;
        if (shown && chan == upper_i) at_upper_count++;
        if (recent_reset) begin
            next_s1.hsync  = 1'b0;
            next_s1.vsync  = 1'b0;
            next_s1.active = 1'b0;
            stage2         = '0;
        end else begin
            stage2 = expected_video(stage1);
        end
        stage1 = next_s1;
        // Frame start flag follows the wrap from the last position
        exp_new_frame = !recent_reset && exp_h == H_TOTAL - 1 && exp_v == V_TOTAL - 1;
        if (recent_reset || exp_new_frame) begin
            exp_h = 0;
            exp_v = 0;
        end else if (exp_h == H_TOTAL - 1) begin
            exp_h = 0;
            exp_v++;
        end else begin
            exp_h++;
        end
    endtask

    task automatic check_outputs();
        assert (int'(hcount_o) == exp_h && int'(vcount_o) == exp_v) else begin
            $display("error: %s position expected %0d,%0d actual %0d,%0d",
                     test_name, exp_h, exp_v, hcount_o, vcount_o);
            stop_on_error();
        end
        assert (new_frame_o == exp_new_frame) else begin
            $display("error: %s new_frame_o expected %b actual %b",
                     test_name, exp_new_frame, new_frame_o);
            stop_on_error();
        end
        assert ({hsync_o, vsync_o, de_o} == {stage2.hsync, stage2.vsync, stage2.de}) else begin
            $display("error: %s hsync,vsync,de expected %b%b%b actual %b%b%b", test_name,
                     stage2.hsync, stage2.vsync, stage2.de, hsync_o, vsync_o, de_o);
            stop_on_error();
        end
        assert (rgb_o == stage2.rgb) else begin
            $display("error: %s rgb_o expected %h actual %h", test_name, stage2.rgb, rgb_o);
            stop_on_error();
        end
        if (de_o) de_count++;
        if (hsync_o) hsync_count++;
        if (vsync_o) vsync_count++;
        if (new_frame_o) frame_count++;
        if (de_o && rgb_o == COLOR_CROSS) cross_count++;
        if (de_o && rgb_o == COLOR_GOOD) good_count++;
        if (de_o && rgb_o == COLOR_BAD) bad_count++;
        if (de_o && rgb_o == 24'hFFFFFF) white_count++;
    endtask

    task automatic drive_pixel();
        pixel_i = frame_mem[int'(vcount_o) * H_TOTAL + int'(hcount_o)];
    endtask

    task automatic run_cycle();
        advance_model();
        @(posedge clk_pixel);
        @(negedge clk_pixel);
        check_outputs();
        drive_pixel();
    endtask

    task automatic clear_counts();
        de_count       = 0;
        hsync_count    = 0;
        vsync_count    = 0;
        frame_count    = 0;
        cross_count    = 0;
        good_count     = 0;
        bad_count      = 0;
        white_count    = 0;
        at_lower_count = 0;
        at_upper_count = 0;
    endtask

    task automatic expect_count(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic require_seen(input string what, input int count);
        assert (count > 0) else begin
            $display("%s: no %s during the frame", test_name, what);
            stop_on_error();
        end
    endtask

    task automatic test_reset_timing();
        test_name   = "reset_timing";
        num_balls_i = 2'd0;
        clear_counts();
        run_cycle();
        assert (!de_o && !hsync_o && !vsync_o && rgb_o == 24'h000000) else begin
            $display("%s: video outputs not low right after reset", test_name);
            stop_on_error();
        end
        repeat (FRAME_CYCLES - 1) run_cycle();
        expect_count("new_frame_o pulses", 1, frame_count);
        expect_count("de_o cycles", H_ACTIVE * V_ACTIVE, de_count);
        expect_count("hsync_o cycles", (H_SYNC_END - H_SYNC_START) * V_TOTAL, hsync_count);
        expect_count("vsync_o cycles", (V_SYNC_END - V_SYNC_START) * H_TOTAL, vsync_count);
    endtask

    task automatic test_camera_view();
        test_name   = "camera_view";
        mask_view_i = 1'b0;
        num_balls_i = 2'd0;
        clear_counts();
        repeat (FRAME_CYCLES) run_cycle();
        expect_count("de_o cycles", H_ACTIVE * V_ACTIVE, de_count);
    endtask

    // Bounds on the channel's step size so both edges occur in random data
    task automatic test_threshold(input string name, input logic [1:0] sel,
                                  input logic [7:0] lo, input logic [7:0] hi);
        test_name   = name;
        mask_view_i = 1'b1;
        num_balls_i = 2'd0;
        chan_sel_i  = sel;
        lower_i     = lo;
        upper_i     = hi;
        clear_counts();
        repeat (FRAME_CYCLES) run_cycle();
        require_seen("pixels equal to the lower bound", at_lower_count);
        require_seen("pixels equal to the upper bound", at_upper_count);
        require_seen("mask pixels", white_count);
    endtask

    task automatic test_crosshairs(input string name, input logic [1:0] balls, input int pixels);
        test_name         = name;
        mask_view_i       = 1'b0;
        pattern_correct_i = 1'b0;
        ball_x_i          = {HCOUNT_W'(61), HCOUNT_W'(20)}; // Ball 1 sits on the border
        ball_y_i          = {VCOUNT_W'(3), VCOUNT_W'(24)};
        num_balls_i       = balls;
        clear_counts();
        repeat (FRAME_CYCLES) run_cycle();
        expect_count("crosshair pixels", pixels, cross_count);
    endtask

    task automatic test_border(input string name, input logic correct);
        test_name         = name;
        mask_view_i       = 1'b1;
        num_balls_i       = 2'd0;
        pattern_correct_i = correct;
        clear_counts();
        repeat (FRAME_CYCLES) run_cycle();
        // 64x48 window minus the 56x40 interior
        expect_count("green border pixels", correct ? 832 : 0, good_count);
        expect_count("red border pixels", correct ? 0 : 832, bad_count);
    endtask

    initial begin
        recent_reset      = 1'b1;
        pixel_i           = '0;
        chan_sel_i        = 2'd0;
        lower_i           = 8'h00;
        upper_i           = 8'hFF;
        mask_view_i       = 1'b0;
        ball_x_i          = '0;
        ball_y_i          = '0;
        num_balls_i       = 2'd0;
        pattern_correct_i = 1'b1;
        stage1            = '0;
        stage2            = '0;
        exp_h             = 0;
        exp_v             = 0;
        exp_new_frame     = 1'b0;
        test_name         = "reset";
        clear_counts();
        void'($urandom(32'hdba5dab3));
        for (int i = 0; i < FRAME_CYCLES; i++)
            frame_mem[i] = PIXEL565_W'($urandom);

        @(posedge clk_pixel); // First reset edge
        @(negedge clk_pixel);
        drive_pixel();
        run_cycle();          // Second reset edge
        recent_reset = 1'b0;

        test_reset_timing();
        test_camera_view();
        test_threshold("threshold_red", 2'd0, 8'h40, 8'hA0);
        test_threshold("threshold_green", 2'd1, 8'h24, 8'hC8);
        test_threshold("threshold_blue", 2'd2, 8'h18, 8'h78);
        test_threshold("threshold_code3", 2'd3, 8'h80, 8'hF8);
        test_crosshairs("crosshair_one", 2'd1, 93);  // Full cross, 51 + 51 - 9
        test_crosshairs("crosshair_two", 2'd2, 153); // Clipped cross adds 36 + 33 - 9
        test_border("border_good", 1'b1);
        test_border("border_bad", 1'b0);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
